// ==== sd_card_top.f ====
+incdir+logic
logic/sd_card_pkg.sv
logic/sd_xfer_if.sv
logic/sd_block_mem.sv
logic/sd_data_rx.sv
logic/sd_data_tx.sv
logic/sd_card_state.sv
logic/sd_card_top.sv
test/tb_sd_card.sv

// ==== Makefile ====
# Verilator simulation of the SD card core testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_card
FILELIST  ?= sd_card_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), judge the log $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_sd_card.sv ====
// Self-checking testbench for the SD card core: command table, block write and read back
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module tb_sd_card
	import sd_card_pkg::*;
();

	localparam int N_STEPS = 33;
	// Table steps plus two block transfers, generous per-cycle margin
	localparam int WATCHDOG_CYCLES = (N_STEPS + 2 * 130) * 40;
	localparam int XFER_WAIT = 1000;

	// What follows the command of a step
	localparam int ACT_CMD = 0;
	localparam int ACT_WRITE = 1;
	localparam int ACT_READ = 2;

	// Card state codes as seen in R1
	localparam logic [3:0] ST_STBY = 4'd3;
	localparam logic [3:0] ST_TRAN = 4'd4;

	// ACMD41 argument pieces
	localparam cmd_arg_t HCS = 32'h4000_0000;
	localparam cmd_arg_t VDD_ARG = {8'h00, `SD_OCR_VDD, 8'h00};
	// First and second published RCA, in argument position
	localparam cmd_arg_t RCA0 = {`SD_RCA_SEED, 16'h0000};
	localparam cmd_arg_t RCA1 = {`SD_RCA_SEED + 16'd1, 16'h0000};

	logic        sd_clk;
	logic        i_rst_n;
	logic        i_cmd_valid;
	cmd_index_t  i_cmd_index;
	cmd_arg_t    i_cmd_arg;
	logic        i_reply_busy;
	logic        i_rx_valid;
	word_t       i_rx_data;
	logic        i_tx_ready;
	logic        o_reply_valid;
	cmd_index_t  o_reply_index;
	logic        o_reply_long;
	long_reply_t o_reply_arg;
	logic        o_tx_valid;
	word_t       o_tx_data;
	logic        o_tx_last;
	logic        o_card_busy;

	// Step table, one entry per command
	string       step_name [N_STEPS];
	cmd_index_t  step_idx [N_STEPS];
	cmd_arg_t    step_arg [N_STEPS];
	logic        step_rsp [N_STEPS];
	cmd_index_t  step_rsp_idx [N_STEPS];
	logic        step_long [N_STEPS];
	long_reply_t step_payload [N_STEPS];
	int          step_act [N_STEPS];
	int          n_steps;

	logic [31:0] lfsr;
	// Block 5 contents as written
	word_t       block_data [`SD_BLOCK_WORDS];
	int          errors;
	int          checks;
	int          step_errors;
	int          steps_failed;

	sd_card_top uut (
		.sd_clk        (sd_clk),
		.i_rst_n       (i_rst_n),
		.i_cmd_valid   (i_cmd_valid),
		.i_cmd_index   (i_cmd_index),
		.i_cmd_arg     (i_cmd_arg),
		.i_reply_busy  (i_reply_busy),
		.o_reply_valid (o_reply_valid),
		.o_reply_index (o_reply_index),
		.o_reply_long  (o_reply_long),
		.o_reply_arg   (o_reply_arg),
		.i_rx_valid    (i_rx_valid),
		.i_rx_data     (i_rx_data),
		.o_tx_valid    (o_tx_valid),
		.o_tx_data     (o_tx_data),
		.o_tx_last     (o_tx_last),
		.i_tx_ready    (i_tx_ready),
		.o_card_busy   (o_card_busy)
	);

	// 20 ns period
	always #10 sd_clk = ~sd_clk;

	////////////////////////////////////////////////////////////
	// Random source and expected values

	// Galois LFSR, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// R1: state in 12:9, APP_CMD in bit 5
	function automatic long_reply_t r1_reply(input logic [3:0] st, input logic app);
		return long_reply_t'({19'd0, st, 3'd0, app, 5'd0});
	endfunction

	// R3: busy/done in 31, CCS in 30, window in 23:8
	function automatic long_reply_t ocr_reply(input logic done, input logic ccs);
		return long_reply_t'({done, ccs, 6'd0, `SD_OCR_VDD, 8'd0});
	endfunction

	////////////////////////////////////////////////////////////
	// Reporting

	task automatic show_mismatch(input string name, input string what,
		input long_reply_t exp, input long_reply_t act);
		$display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
		step_errors++;
	endtask

	task automatic note_error(input string name, input string what);
		$display("%s: %s", name, what);
		step_errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Step table

	task automatic add_step(input string name, input int idx, input cmd_arg_t arg,
		input logic rsp, input int rsp_idx, input logic lng, input long_reply_t pay,
		input int act);
		step_name[n_steps] = name;
		step_idx[n_steps] = cmd_index_t'(idx);
		step_arg[n_steps] = arg;
		step_rsp[n_steps] = rsp;
		step_rsp_idx[n_steps] = cmd_index_t'(rsp_idx);
		step_long[n_steps] = lng;
		step_payload[n_steps] = pay;
		step_act[n_steps] = act;
		n_steps++;
	endtask

	task automatic build_table();
		long_reply_t echo;
		echo = long_reply_t'(32'h1aa);
		// Identification with HCS
		add_step("cmd0 reset", 0, '0, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("cmd8 echo", 8, 32'h1aa, 1'b1, 8, 1'b0, echo, ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 hcs poll 1", 41, HCS | VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b0, 1'b1), ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 hcs poll 2", 41, HCS | VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b0, 1'b1), ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 hcs poll 3", 41, HCS | VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b1, 1'b1), ACT_CMD);
		add_step("cmd2 cid", 2, '0, 1'b1, 63, 1'b1, `SD_CID, ACT_CMD);
		add_step("cmd3 rca", 3, '0, 1'b1, 3, 1'b0, long_reply_t'(RCA0), ACT_CMD);
		add_step("cmd10 cid", 10, RCA0, 1'b1, 10, 1'b1, `SD_CID, ACT_CMD);
		// Rejections, card in STBY
		add_step("cmd17 unselected", 17, 32'd5, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("unknown cmd5", 5, '0, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("cmd8 bad pattern", 8, 32'h1bb, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("cmd2 after ident", 2, '0, 1'b0, 0, 1'b0, '0, ACT_CMD);
		// Selection
		add_step("cmd7 wrong rca", 7, 32'hdead_0000, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("cmd7 select", 7, RCA0, 1'b1, 7, 1'b0, r1_reply(ST_STBY, 1'b0), ACT_CMD);
		add_step("cmd55 tran", 55, RCA0, 1'b1, 55, 1'b0, r1_reply(ST_TRAN, 1'b1), ACT_CMD);
		// Block mode write then read of block 5
		add_step("cmd24 block 5", 24, 32'd5, 1'b1, 24, 1'b0, r1_reply(ST_TRAN, 1'b0),
			ACT_WRITE);
		add_step("cmd17 block 5", 17, 32'd5, 1'b1, 17, 1'b0, r1_reply(ST_TRAN, 1'b0),
			ACT_READ);
		// Second init without HCS, byte addressing
		add_step("cmd0 soft reset", 0, '0, 1'b0, 0, 1'b0, '0, ACT_CMD);
		add_step("cmd8 echo", 8, 32'h1aa, 1'b1, 8, 1'b0, echo, ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 sdsc poll 1", 41, VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b0, 1'b0), ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 sdsc poll 2", 41, VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b0, 1'b0), ACT_CMD);
		add_step("cmd55 idle", 55, '0, 1'b1, 55, 1'b0, r1_reply(4'd0, 1'b1), ACT_CMD);
		add_step("acmd41 sdsc poll 3", 41, VDD_ARG, 1'b1, 63, 1'b0,
			ocr_reply(1'b1, 1'b0), ACT_CMD);
		add_step("cmd2 cid", 2, '0, 1'b1, 63, 1'b1, `SD_CID, ACT_CMD);
		add_step("cmd3 next rca", 3, '0, 1'b1, 3, 1'b0, long_reply_t'(RCA1), ACT_CMD);
		add_step("cmd7 select", 7, RCA1, 1'b1, 7, 1'b0, r1_reply(ST_STBY, 1'b0), ACT_CMD);
		// Byte 2560 is block 5
		add_step("cmd17 byte addr", 17, 32'd2560, 1'b1, 17, 1'b0, r1_reply(ST_TRAN, 1'b0),
			ACT_READ);
		add_step("cmd2 in tran", 2, '0, 1'b0, 0, 1'b0, '0, ACT_CMD);
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks

	// One command strobe, reply due right after the accepting edge
	task automatic send_command(input int s);
		logic got;
		@(posedge sd_clk);
		i_cmd_valid <= 1'b1;
		i_cmd_index <= step_idx[s];
		i_cmd_arg <= step_arg[s];
		@(posedge sd_clk);
		i_cmd_valid <= 1'b0;
		@(negedge sd_clk);
		got = o_reply_valid;
		checks++;
		if (got && !step_rsp[s])
			note_error(step_name[s], $sformatf("unexpected reply, index %0d", o_reply_index));
		else if (!got && step_rsp[s])
			note_error(step_name[s], "no reply from the card");
		else if (got)
		begin
			checks++;
			if (o_reply_index !== step_rsp_idx[s])
				show_mismatch(step_name[s], "reply index", long_reply_t'(step_rsp_idx[s]),
					long_reply_t'(o_reply_index));
			checks++;
			if (o_reply_long !== step_long[s])
				show_mismatch(step_name[s], "long flag", long_reply_t'(step_long[s]),
					long_reply_t'(o_reply_long));
			checks++;
			if (o_reply_arg !== step_payload[s])
				show_mismatch(step_name[s], "payload", step_payload[s], o_reply_arg);
			// Serializer is free, so the reply lasts one cycle
			@(negedge sd_clk);
			checks++;
			if (o_reply_valid)
				note_error(step_name[s], "reply valid held past one cycle");
		end
	endtask

	// Card busy must drop once the data path is done
	task automatic wait_idle(input string name);
		int k;
		k = 0;
		do
		begin
			@(negedge sd_clk);
			k++;
		end
		while (o_card_busy && k < XFER_WAIT);
		checks++;
		if (o_card_busy)
			note_error(name, "card busy did not fall after the transfer");
	endtask

	// Fresh LFSR block, sent with random gaps
	task automatic write_block(input string name);
		logic [31:0] gate;
		int n;
		int i;
		for (i = 0; i < `SD_BLOCK_WORDS; i++)
			take_bits(32, block_data[i]);
		checks++;
		if (!o_card_busy)
			note_error(name, "card not busy after accepting the write");
		// Write busy is up by the second edge from here
		repeat (2) @(posedge sd_clk);
		n = 0;
		while (n < `SD_BLOCK_WORDS)
		begin
			@(posedge sd_clk);
			take_bits(1, gate);
			if (gate[0])
			begin
				i_rx_valid <= 1'b1;
				i_rx_data <= block_data[n];
				n++;
			end
			else
				i_rx_valid <= 1'b0;
		end
		@(posedge sd_clk);
		i_rx_valid <= 1'b0;
		wait_idle(name);
	endtask

	// Stream compare under random back-pressure
	task automatic read_block(input string name);
		logic [31:0] gate;
		int n;
		int k;
		checks++;
		if (!o_card_busy)
			note_error(name, "card not busy after accepting the read");
		n = 0;
		k = 0;
		while (n < `SD_BLOCK_WORDS && k < XFER_WAIT)
		begin
			@(posedge sd_clk);
			take_bits(1, gate);
			i_tx_ready <= gate[0];
			@(negedge sd_clk);
			k++;
			// Word moves on the coming edge
			if (o_tx_valid && i_tx_ready)
			begin
				checks++;
				if (o_tx_data !== block_data[n])
					show_mismatch(name, $sformatf("word %0d", n),
						long_reply_t'(block_data[n]), long_reply_t'(o_tx_data));
				checks++;
				if (o_tx_last !== (n == `SD_BLOCK_WORDS - 1))
					show_mismatch(name, $sformatf("last flag at word %0d", n),
						long_reply_t'(n == `SD_BLOCK_WORDS - 1), long_reply_t'(o_tx_last));
				n++;
			end
		end
		checks++;
		if (n < `SD_BLOCK_WORDS)
			note_error(name, $sformatf("read stream stopped after %0d words", n));
		@(posedge sd_clk);
		i_tx_ready <= 1'b0;
		wait_idle(name);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		int s;
		sd_clk = 1'b0;
		i_rst_n = 1'b0;
		i_cmd_valid = 1'b0;
		i_cmd_index = '0;
		i_cmd_arg = '0;
		// Serializer always free
		i_reply_busy = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data = '0;
		i_tx_ready = 1'b0;
		lfsr = 32'h6de5;
		n_steps = 0;
		errors = 0;
		checks = 0;
		steps_failed = 0;
		build_table();

		repeat (10) @(posedge sd_clk);
		i_rst_n <= 1'b1;
		@(negedge sd_clk);
		step_errors = 0;
		checks++;
		if (o_reply_valid || o_tx_valid || o_tx_last || o_card_busy)
			note_error("reset", "outputs not idle after reset");
		errors += step_errors;
		if (step_errors != 0)
			steps_failed++;
		$display("reset values: %0d error(s)", step_errors);

		for (s = 0; s < n_steps; s++)
		begin
			step_errors = 0;
			send_command(s);
			if (step_act[s] == ACT_WRITE)
				write_block(step_name[s]);
			else if (step_act[s] == ACT_READ)
				read_block(step_name[s]);
			errors += step_errors;
			if (step_errors == 0)
				$display("step %2d  %-22s ok", s, step_name[s]);
			else
			begin
				steps_failed++;
				$display("step %2d  %-22s %0d error(s)", s, step_name[s], step_errors);
			end
		end

		$display("%0d steps, %0d failed, %0d checks, %0d errors",
			n_steps, steps_failed, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Hang guard
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge sd_clk);
		$display("watchdog: run exceeded %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/sd_card_top.sv ====
// SD card device core top level, decoded commands in and replies out
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module sd_card_top
	import sd_card_pkg::*;
(
	input  wire              sd_clk,
	input  wire              i_rst_n,
	// Command in, reply out
	input  wire              i_cmd_valid,
	input  wire cmd_index_t  i_cmd_index,
	input  wire cmd_arg_t    i_cmd_arg,
	input  wire              i_reply_busy,
	output logic             o_reply_valid,
	output cmd_index_t       o_reply_index,
	output logic             o_reply_long,
	output long_reply_t      o_reply_arg,
	// Block write stream
	input  wire              i_rx_valid,
	input  wire word_t       i_rx_data,
	// Block read stream
	output logic             o_tx_valid,
	output word_t            o_tx_data,
	output logic             o_tx_last,
	input  wire              i_tx_ready,
	output logic             o_card_busy
);

	logic mem_we;
	logic [`SD_LG_BLOCKS+`SD_WORD_IDX_W-1:0] mem_waddr;
	word_t mem_wdata;
	logic [`SD_LG_BLOCKS+`SD_WORD_IDX_W-1:0] mem_raddr;
	word_t mem_rdata;

	// Transfer requests and status
	sd_xfer_if xfer ();

	////////////////////////////////////////////////////////////
	// Command side

	sd_card_state u_state (
		.sd_clk        (sd_clk),
		.i_rst_n       (i_rst_n),
		.i_cmd_valid   (i_cmd_valid),
		.i_cmd_index   (i_cmd_index),
		.i_cmd_arg     (i_cmd_arg),
		.i_reply_busy  (i_reply_busy),
		.o_reply_valid (o_reply_valid),
		.o_reply_index (o_reply_index),
		.o_reply_long  (o_reply_long),
		.o_reply_arg   (o_reply_arg),
		.o_card_busy   (o_card_busy),
		.xfer          (xfer.ctrl)
	);

	////////////////////////////////////////////////////////////
	// Data paths and storage

	sd_data_rx u_rx (
		.sd_clk      (sd_clk),
		.i_rst_n     (i_rst_n),
		.i_rx_valid  (i_rx_valid),
		.i_rx_data   (i_rx_data),
		.xfer        (xfer.wr),
		.o_mem_we    (mem_we),
		.o_mem_addr  (mem_waddr),
		.o_mem_wdata (mem_wdata)
	);

	sd_data_tx u_tx (
		.sd_clk      (sd_clk),
		.i_rst_n     (i_rst_n),
		.i_tx_ready  (i_tx_ready),
		.i_mem_rdata (mem_rdata),
		.xfer        (xfer.rd),
		.o_mem_raddr (mem_raddr),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data),
		.o_tx_last   (o_tx_last)
	);

	sd_block_mem u_mem (
		.sd_clk  (sd_clk),
		.i_we    (mem_we),
		.i_waddr (mem_waddr),
		.i_wdata (mem_wdata),
		.i_raddr (mem_raddr),
		.o_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/sd_card_state.sv ====
// SD card command decoder, card FSM, OCR/RCA/CID handling and reply builder
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module sd_card_state
	import sd_card_pkg::*;
(
	input  wire              sd_clk,
	input  wire              i_rst_n,
	input  wire              i_cmd_valid,
	input  wire cmd_index_t  i_cmd_index,
	input  wire cmd_arg_t    i_cmd_arg,
	input  wire              i_reply_busy,
	output logic             o_reply_valid,
	output cmd_index_t       o_reply_index,
	output logic             o_reply_long,
	output long_reply_t      o_reply_arg,
	output logic             o_card_busy,
	sd_xfer_if.ctrl          xfer
);

	localparam int POLL_W = $clog2(`SD_POWERUP_POLLS + 1);

	card_state_t state;
	logic app_cmd;
	logic cmd8_seen;
	logic host_hcs;
	logic [POLL_W-1:0] poll_cnt;
	rca_t rca;
	rca_t rca_ctr;
	logic xfer_pend;
	logic xfer_wr;

	cmd_arg_t r1;
	cmd_arg_t ocr;
	logic rca_match, vdd_ok, pwr_done, ccs, xfer_idle;
	logic do_acmd41, do_cmd0, do_cmd2, do_cmd3, do_sel, do_desel;
	logic do_cmd8, do_cmd10, do_cmd55, do_xfer;
	logic rsp_due, rsp_long;
	cmd_index_t rsp_index;
	long_reply_t rsp_arg;

	////////////////////////////////////////////////////////////
	// Command qualification

	// R1 status, current state only
	assign r1 = {19'd0, state, 9'd0};
	assign rca_match = (i_cmd_arg[31:16] == rca);
	// Host window must overlap ours for a poll to count
	assign vdd_ok = |(i_cmd_arg[23:8] & `SD_OCR_VDD);
	assign pwr_done = vdd_ok && (poll_cnt >= POLL_W'(`SD_POWERUP_POLLS - 1));
	assign ccs = cmd8_seen && i_cmd_arg[30];
	assign ocr = {pwr_done, ccs, 6'd0, `SD_OCR_VDD, 8'd0};
	// Nothing queued, starting or running
	assign xfer_idle = !xfer_pend && !xfer.start_read && !xfer.start_write
		&& !xfer.wr_busy && !xfer.rd_busy;

	assign do_acmd41 = app_cmd && (i_cmd_index == 6'd41) && (state == IDLE || state == READY);
	assign do_cmd0 = (i_cmd_index == 6'd0);
	assign do_cmd2 = (i_cmd_index == 6'd2) && (state == READY);
	assign do_cmd3 = (i_cmd_index == 6'd3) && (state == IDENT || state == STBY);
	assign do_sel = (i_cmd_index == 6'd7) && rca_match && (state == STBY || state == TRAN);
	assign do_desel = (i_cmd_index == 6'd7) && !rca_match;
	assign do_cmd8 = (i_cmd_index == 6'd8) && (i_cmd_arg[7:0] == `SD_CHECK_PATTERN);
	assign do_cmd10 = (i_cmd_index == 6'd10) && rca_match && (state == STBY);
	assign do_cmd55 = (i_cmd_index == 6'd55);
	// Single block read or write, selected and quiet
	assign do_xfer = (i_cmd_index == 6'd17 || i_cmd_index == 6'd24)
		&& (state == TRAN) && xfer_idle;

	// Busy while a block is moving
	assign o_card_busy = (state == DATA) || (state == RCV);

	////////////////////////////////////////////////////////////
	// Reply selection

	always_comb
	begin
		rsp_due = 1'b1;
		rsp_long = 1'b0;
		rsp_index = i_cmd_index;
		rsp_arg = long_reply_t'(r1);
		if (do_acmd41)
		begin
			// R3 carries index 63
			rsp_index = 6'd63;
			rsp_arg = long_reply_t'(ocr);
		end
		else if (do_cmd2 || do_cmd10)
		begin
			rsp_long = 1'b1;
			rsp_arg = `SD_CID;
			if (do_cmd2)
				rsp_index = 6'd63;
		end
		else if (do_cmd3)
			rsp_arg = long_reply_t'({rca_ctr, 16'd0});
		else if (do_cmd8)
			rsp_arg = long_reply_t'(i_cmd_arg);
		else if (do_cmd55)
			// APP_CMD status bit
			rsp_arg = long_reply_t'(r1 | 32'h20);
		else if (!(do_sel || do_xfer))
			rsp_due = 1'b0;
	end

	// Reply payload, loaded with the command
	always_ff @(posedge sd_clk)
	begin
		if (i_cmd_valid && rsp_due)
		begin
			o_reply_index <= rsp_index;
			o_reply_long <= rsp_long;
			o_reply_arg <= rsp_arg;
		end
	end

	// Block number, byte address divided down unless HCS
	always_ff @(posedge sd_clk)
	begin
		if (i_cmd_valid && do_xfer)
			xfer.blk_addr <= host_hcs ? i_cmd_arg : (i_cmd_arg >> 9);
	end

	////////////////////////////////////////////////////////////
	// Card FSM

	always_ff @(posedge sd_clk)
	begin
		if (!i_rst_n)
		begin
			state <= IDLE;
			app_cmd <= 1'b0;
			cmd8_seen <= 1'b0;
			host_hcs <= 1'b0;
			poll_cnt <= '0;
			rca <= '0;
			rca_ctr <= `SD_RCA_SEED;
			xfer_pend <= 1'b0;
			xfer_wr <= 1'b0;
			o_reply_valid <= 1'b0;
			xfer.start_read <= 1'b0;
			xfer.start_write <= 1'b0;
		end
		else
		begin
			xfer.start_read <= 1'b0;
			xfer.start_write <= 1'b0;
			// Serializer took the reply
			if (o_reply_valid && !i_reply_busy)
				o_reply_valid <= 1'b0;
			// Start only after the reply is gone
			if (xfer_pend && (!o_reply_valid || !i_reply_busy))
			begin
				xfer_pend <= 1'b0;
				xfer.start_write <= xfer_wr;
				xfer.start_read <= !xfer_wr;
			end
			// Data path done, back to transfer state
			if (o_card_busy && xfer_idle)
				state <= TRAN;

			if (i_cmd_valid)
			begin
				app_cmd <= do_cmd55;
				if (rsp_due)
					o_reply_valid <= 1'b1;
				if (do_acmd41)
				begin
					host_hcs <= ccs;
					if (vdd_ok && poll_cnt != POLL_W'(`SD_POWERUP_POLLS))
						poll_cnt <= poll_cnt + 1'b1;
					if (pwr_done)
						state <= READY;
				end
				if (do_cmd8)
					cmd8_seen <= 1'b1;
				if (do_cmd2)
					state <= IDENT;
				if (do_cmd3)
				begin
					// Publish and advance
					rca <= rca_ctr;
					rca_ctr <= rca_ctr + 1'b1;
					state <= STBY;
				end
				if (do_sel)
					state <= TRAN;
				if (do_desel && state == TRAN)
					state <= STBY;
				if (do_xfer)
				begin
					xfer_pend <= 1'b1;
					xfer_wr <= (i_cmd_index == 6'd24);
					state <= (i_cmd_index == 6'd24) ? RCV : DATA;
				end
				// Soft reset wins over everything
				if (do_cmd0)
				begin
					state <= IDLE;
					cmd8_seen <= 1'b0;
					host_hcs <= 1'b0;
					poll_cnt <= '0;
					rca <= '0;
					xfer_pend <= 1'b0;
					xfer.start_read <= 1'b0;
					xfer.start_write <= 1'b0;
				end
			end
		end
	end

	// No data path is asked to start while one is still running
	a_start_idle: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		(xfer.start_read || xfer.start_write) |-> !(xfer.rd_busy || xfer.wr_busy));

endmodule

`default_nettype wire

// ==== logic/sd_data_tx.sv ====
// Block read path: memory words streamed out under valid/ready
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module sd_data_tx
	import sd_card_pkg::*;
(
	input  wire                                      sd_clk,
	input  wire                                      i_rst_n,
	input  wire                                      i_tx_ready,
	input  wire word_t                               i_mem_rdata,
	sd_xfer_if.rd                                    xfer,
	output logic [`SD_LG_BLOCKS+`SD_WORD_IDX_W-1:0]  o_mem_raddr,
	output logic                                     o_tx_valid,
	output word_t                                    o_tx_data,
	output logic                                     o_tx_last
);

	logic [`SD_LG_BLOCKS-1:0] a_blk;
	word_idx_t a_idx;
	logic a_act;
	// Word held by the memory read register
	logic m_vld, m_last;
	// Skid entry for a stalled word
	logic s_vld, s_last;
	word_t s_data;
	logic take, issue;

	assign take = o_tx_valid && i_tx_ready;
	// Read ahead only if the word in flight has somewhere to go
	assign issue = a_act && (!o_tx_valid || i_tx_ready);

	assign o_mem_raddr = {a_blk, a_idx};
	// Skid first, it is always older
	assign o_tx_valid = s_vld || m_vld;
	assign o_tx_data = s_vld ? s_data : i_mem_rdata;
	assign o_tx_last = s_vld ? s_last : m_last;

	always_ff @(posedge sd_clk)
	begin
		if (!i_rst_n)
		begin
			xfer.rd_busy <= 1'b0;
			a_act <= 1'b0;
			a_idx <= '0;
			m_vld <= 1'b0;
			m_last <= 1'b0;
			s_vld <= 1'b0;
			s_last <= 1'b0;
		end
		else
		begin
			m_vld <= issue;
			m_last <= issue && (&a_idx);
			// Address counter
			if (xfer.start_read)
			begin
				xfer.rd_busy <= 1'b1;
				a_act <= 1'b1;
				a_idx <= '0;
			end
			else if (issue)
			begin
				a_idx <= a_idx + 1'b1;
				if (&a_idx)
					a_act <= 1'b0;
			end
			// Skid fill and drain
			if (s_vld)
			begin
				if (i_tx_ready)
					s_vld <= 1'b0;
			end
			else if (m_vld && !i_tx_ready)
			begin
				s_vld <= 1'b1;
				s_last <= m_last;
			end
			// Last word taken
			if (take && o_tx_last)
				xfer.rd_busy <= 1'b0;
		end
	end

	always_ff @(posedge sd_clk)
	begin
		if (xfer.start_read)
			a_blk <= xfer.blk_addr[`SD_LG_BLOCKS-1:0];
		if (!s_vld && m_vld && !i_tx_ready)
			s_data <= i_mem_rdata;
	end

	a_hold: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		(o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_data)));

endmodule

`default_nettype wire

// ==== logic/sd_data_rx.sv ====
// Block write path: host word strobes into block memory
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module sd_data_rx
	import sd_card_pkg::*;
(
	input  wire                                      sd_clk,
	input  wire                                      i_rst_n,
	input  wire                                      i_rx_valid,
	input  wire word_t                               i_rx_data,
	sd_xfer_if.wr                                    xfer,
	output logic                                     o_mem_we,
	output logic [`SD_LG_BLOCKS+`SD_WORD_IDX_W-1:0]  o_mem_addr,
	output word_t                                    o_mem_wdata
);

	logic [`SD_LG_BLOCKS-1:0] blk;
	word_idx_t idx;

	// Words count only inside an active block
	assign o_mem_we = xfer.wr_busy && i_rx_valid;
	// Block times 128 plus word index
	assign o_mem_addr = {blk, idx};
	assign o_mem_wdata = i_rx_data;

	always_ff @(posedge sd_clk)
	begin
		if (!i_rst_n)
		begin
			xfer.wr_busy <= 1'b0;
			idx <= '0;
		end
		else if (xfer.start_write)
		begin
			xfer.wr_busy <= 1'b1;
			idx <= '0;
		end
		else if (o_mem_we)
		begin
			idx <= idx + 1'b1;
			// Word 127 closes the block
			if (&idx)
				xfer.wr_busy <= 1'b0;
		end
	end

	// Block number, wraps above memory size
	always_ff @(posedge sd_clk)
	begin
		if (xfer.start_write)
			blk <= xfer.blk_addr[`SD_LG_BLOCKS-1:0];
	end

	a_no_restart: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		xfer.start_write |-> !xfer.wr_busy);

endmodule

`default_nettype wire

// ==== logic/sd_block_mem.sv ====
// Card block memory, one write port and one registered read port
`timescale 1ns/100ps
`default_nettype none

`include "sd_card_defs.svh"

module sd_block_mem
	import sd_card_pkg::*;
#(
	parameter int LG_BLOCKS = `SD_LG_BLOCKS,
	localparam int AW = LG_BLOCKS + `SD_WORD_IDX_W
)(
	input  wire          sd_clk,
	input  wire          i_we,
	input  wire [AW-1:0] i_waddr,
	input  wire word_t   i_wdata,
	input  wire [AW-1:0] i_raddr,
	output word_t        o_rdata
);

	// Whole blocks only
	localparam int DEPTH = `SD_BLOCK_WORDS << LG_BLOCKS;

	word_t mem [0:DEPTH-1];

	// Write port
	always_ff @(posedge sd_clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// Read port, one cycle latency
	always_ff @(posedge sd_clk)
	begin
		o_rdata <= mem[i_raddr];
	end

endmodule

`default_nettype wire

// ==== logic/sd_xfer_if.sv ====
// Block transfer channel between the command logic and the two data paths
`timescale 1ns/100ps
`default_nettype none

interface sd_xfer_if
	import sd_card_pkg::*;
();

	// One-cycle request pulses from the command logic
	logic start_write;
	logic start_read;

	// Block number, valid with either start pulse
	blk_addr_t blk_addr;

	// Transfer in progress, one per direction
	logic wr_busy;
	logic rd_busy;

	////////////////////////////////////////////////////////////
	// Views

	// Command FSM side
	modport ctrl (
		output start_write,
		output start_read,
		output blk_addr,
		input  wr_busy,
		input  rd_busy
	);

	// Write path, host words into memory
	modport wr (
		input  start_write,
		input  blk_addr,
		output wr_busy
	);

	// Read path, memory words out to host
	modport rd (
		input  start_read,
		input  blk_addr,
		output rd_busy
	);

endinterface

`default_nettype wire

// ==== logic/sd_card_pkg.sv ====
// Shared types of the SD card core: command, reply, data and card state
`default_nettype none

`include "sd_card_defs.svh"

package sd_card_pkg;

	// Command index as decoded from the CMD line
	typedef logic [5:0] cmd_index_t;

	// Command argument, also a short reply payload
	typedef logic [31:0] cmd_arg_t;

	// Long reply payload, R2 without CRC
	typedef logic [119:0] long_reply_t;

	// One word of a block stream
	typedef logic [31:0] word_t;

	// Relative card address
	typedef logic [15:0] rca_t;

	// Word position within a block
	typedef logic [`SD_WORD_IDX_W-1:0] word_idx_t;

	// Block number, low bits select memory, upper bits wrap
	typedef logic [31:0] blk_addr_t;

	// Card state codes as reported in R1 bits 12:9
	typedef enum logic [3:0] {
		IDLE  = 4'd0,
		READY = 4'd1,
		IDENT = 4'd2,
		STBY  = 4'd3,
		TRAN  = 4'd4,
		DATA  = 4'd5,
		RCV   = 4'd6
	} card_state_t;

endpackage

`default_nettype wire

// ==== logic/sd_card_defs.svh ====
// SD card core constants: block geometry, OCR window, identification values
`ifndef SD_CARD_DEFS_SVH
`define SD_CARD_DEFS_SVH

////////////////////////////////////////////////////////////
// Block geometry

// 512-byte block as 32-bit words
`define SD_BLOCK_WORDS 128
// Word index within one block
`define SD_WORD_IDX_W 7
// Default memory size, log2 of block count
`define SD_LG_BLOCKS 4

////////////////////////////////////////////////////////////
// Identification and power-up

// Supported voltage window, OCR bits 23:8
`define SD_OCR_VDD 16'hff80
// Overlapping ACMD41 polls until power-up is done
`define SD_POWERUP_POLLS 3
// First RCA handed out after reset
`define SD_RCA_SEED 16'h1234
// Fixed CID: MID, OID, PNM, PRV, PSN, reserved, MDT
`define SD_CID {8'h5a, 16'h5254, 40'h5344434f52, 8'h21, 32'h5eed0001, 4'h0, 12'h0c5}
// CMD8 check pattern, argument bits 7:0
`define SD_CHECK_PATTERN 8'haa

`endif
